/* verilog/wbh_pkg.sv */
// wishbone host shared definitions
// request/response bundles, address regions, local register map
// and the address field positions used by the host stages

`default_nettype none

package wbh_pkg;

   // ------------------------------------------------
   // address map
   // ------------------------------------------------
   localparam int REGION_MSB   = 19;             // region field upper bit
   localparam int REGION_LSB   = 18;             // region field lower bit
   localparam int EXT_ADR_BITS = 18;             // master bits passed to slave

   localparam logic [15:0] BANK_SEL_RESET = 16'h1000;

   // adr[19:18] decode, 2'b01 also lands in ext
   typedef enum logic [1:0] {
      REGION_EXT   = 2'b00,
      REGION_LOCAL = 2'b10,
      REGION_RSVD  = 2'b11
   } region_e;

   // local register select, adr[3:2]
   typedef enum logic [1:0] {
      REG_GLB_CTRL  = 2'b00,                     // sw resets in [2:0]
      REG_BANK_SEL  = 2'b01,                     // upper ext address bits
      REG_CLK_CTRL1 = 2'b10,
      REG_CLK_CTRL2 = 2'b11
   } reg_addr_e;

   // ------------------------------------------------
   // bus bundles
   // ------------------------------------------------

   // one master access, held for the whole transfer
   typedef struct packed {
      logic [31:0] adr;
      logic        we;
      logic [31:0] dat;
      logic [3:0]  sel;                          // byte enables
   } wb_req_t;

   // response from any target
   typedef struct packed {
      logic [31:0] dat;                          // read data
      logic        ack;
      logic        err;
   } wb_rsp_t;

endpackage

`default_nettype wire

/* verilog/wbh_req_stage.sv */
// wishbone host request stage
// qualifies stb with cyc, issues one request pulse per access
// and keeps the request fields until the next access

`timescale 1ns/100ps
`default_nettype none

module wbh_req_stage (
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   input  logic              wbm_cyc_i,
   input  logic              wbm_stb_i,
   input  logic [31:0]       wbm_adr_i,
   input  logic              wbm_we_i,
   input  logic [31:0]       wbm_dat_i,
   input  logic [3:0]        wbm_sel_i,
   input  logic              rsp_ack_i,          // registered ack/err on master bus
   input  logic              rsp_pend_i,         // response about to be registered
   output logic              req_vld_o,
   output wbh_pkg::wb_req_t  req_o,
   output wbh_pkg::region_e  region_o
);

   typedef enum logic {
      REQ_IDLE,                                  // ready for a new access
      REQ_WAIT                                   // access in flight
   } req_state_e;

   req_state_e state_q;
   logic       req_take;

   // no new request while a response is still on its way out
   assign req_take = (state_q == REQ_IDLE) && wbm_cyc_i && wbm_stb_i
                     && !rsp_ack_i && !rsp_pend_i;

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         state_q   <= REQ_IDLE;
         req_vld_o <= 1'b0;
      end
      else
      begin
         req_vld_o <= req_take;                  // single cycle pulse
         case (state_q)
            REQ_IDLE: if (req_take) state_q <= REQ_WAIT;
            REQ_WAIT: if (rsp_pend_i) state_q <= REQ_IDLE;
            default:  state_q <= REQ_IDLE;
         endcase
      end
   end

   // request fields, loaded with the pulse
   always_ff @(posedge wbm_clk_i)
   begin
      if (req_take)
         req_o <= '{adr: wbm_adr_i, we: wbm_we_i, dat: wbm_dat_i, sel: wbm_sel_i};
   end

   // region from held address
   always_comb
   begin
      case (req_o.adr[wbh_pkg::REGION_MSB:wbh_pkg::REGION_LSB])
         2'b10:   region_o = wbh_pkg::REGION_LOCAL;
         2'b11:   region_o = wbh_pkg::REGION_RSVD;
         default: region_o = wbh_pkg::REGION_EXT;
      endcase
   end

endmodule

`default_nettype wire

/* verilog/wbh_local_regs.sv */
// wishbone host local configuration registers
// global control, bank select and two clock control words,
// with byte enables on global control and one-cycle acknowledge

`timescale 1ns/100ps
`default_nettype none

module wbh_local_regs #(
   parameter logic [31:0] CLK_CTRL1_RESET = 32'h0,
   parameter logic [31:0] CLK_CTRL2_RESET = 32'h0
) (
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   input  logic              sel_i,              // request pulse, local region
   input  wbh_pkg::wb_req_t  req_i,
   output wbh_pkg::wb_rsp_t  rsp_o,
   output logic [2:0]        glb_ctrl_o,         // sw reset bits
   output logic [15:0]       bank_sel_o,
   output logic [31:0]       clk_ctrl1_o,
   output logic [31:0]       clk_ctrl2_o
);

   wbh_pkg::reg_addr_e reg_addr;
   logic               acc_en;
   logic               wr_en;
   logic               ack_q;
   logic [31:0]        glb_ctrl_q;
   logic [31:0]        rd_mux;
   logic [31:0]        rd_data_q;

   assign reg_addr = wbh_pkg::reg_addr_e'(req_i.adr[3:2]);
   assign acc_en   = sel_i && !ack_q;            // no back to back ack
   assign wr_en    = acc_en && req_i.we;

   // ------------------------------------------------
   // register file
   // ------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         ack_q       <= 1'b0;
         glb_ctrl_q  <= 32'h0;                   // all sw resets asserted
         bank_sel_o  <= wbh_pkg::BANK_SEL_RESET;
         clk_ctrl1_o <= CLK_CTRL1_RESET;
         clk_ctrl2_o <= CLK_CTRL2_RESET;
      end
      else
      begin
         ack_q <= acc_en;
         if (wr_en)
         begin
            case (reg_addr)
               wbh_pkg::REG_GLB_CTRL:
               begin
                  for (int i = 0; i < 4; i++)
                  begin
                     if (req_i.sel[i])
                        glb_ctrl_q[8*i +: 8] <= req_i.dat[8*i +: 8];
                  end
               end
               wbh_pkg::REG_BANK_SEL:  bank_sel_o  <= req_i.dat[15:0];  // low half only
               wbh_pkg::REG_CLK_CTRL1: clk_ctrl1_o <= req_i.dat;
               wbh_pkg::REG_CLK_CTRL2: clk_ctrl2_o <= req_i.dat;
               default: ;
            endcase
         end
      end
   end

   // ------------------------------------------------
   // readback
   // ------------------------------------------------
   always_comb
   begin
      case (reg_addr)
         wbh_pkg::REG_GLB_CTRL:  rd_mux = glb_ctrl_q;
         wbh_pkg::REG_BANK_SEL:  rd_mux = {16'h0, bank_sel_o};  // zero extended
         wbh_pkg::REG_CLK_CTRL1: rd_mux = clk_ctrl1_o;
         wbh_pkg::REG_CLK_CTRL2: rd_mux = clk_ctrl2_o;
         default:                rd_mux = 32'h0;
      endcase
   end

   // read data lines up with the ack
   always_ff @(posedge wbm_clk_i)
   begin
      if (acc_en && !req_i.we)
         rd_data_q <= rd_mux;
   end

   assign glb_ctrl_o = glb_ctrl_q[2:0];
   assign rsp_o      = '{dat: rd_data_q, ack: ack_q, err: 1'b0};  // never errs

endmodule

`default_nettype wire

/* verilog/wbh_ext_port.sv */
// wishbone host external slave port
// extends the master address with the bank select and runs
// one classic wishbone cycle on the slave side per request

`timescale 1ns/100ps
`default_nettype none

module wbh_ext_port (
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   input  logic              sel_i,              // request pulse, ext region
   input  wbh_pkg::wb_req_t  req_i,
   input  logic [15:0]       bank_sel_i,
   output logic              wbs_cyc_o,
   output logic              wbs_stb_o,
   output logic [31:0]       wbs_adr_o,
   output logic              wbs_we_o,
   output logic [31:0]       wbs_dat_o,
   output logic [3:0]        wbs_sel_o,
   input  logic [31:0]       wbs_dat_i,
   input  logic              wbs_ack_i,
   input  logic              wbs_err_i,
   output wbh_pkg::wb_rsp_t  rsp_o
);

   // bank bits above the passed-through master bits
   localparam int BANK_BITS = 32 - wbh_pkg::EXT_ADR_BITS;

   logic busy_q;
   logic slv_done;

   assign slv_done = busy_q && (wbs_ack_i || wbs_err_i);

   // ------------------------------------------------
   // slave cycle control
   // ------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         busy_q <= 1'b0;
      else if (sel_i)
         busy_q <= 1'b1;
      else if (slv_done)
         busy_q <= 1'b0;                         // slave may stretch forever
   end

   assign wbs_cyc_o = busy_q;
   assign wbs_stb_o = busy_q;

   // request fields, stable for the whole slave cycle
   always_ff @(posedge wbm_clk_i)
   begin
      if (sel_i)
      begin
         wbs_adr_o <= {bank_sel_i[15 -: BANK_BITS],
                       req_i.adr[wbh_pkg::EXT_ADR_BITS-1:0]};
         wbs_we_o  <= req_i.we;
         wbs_dat_o <= req_i.dat;
         wbs_sel_o <= req_i.sel;
      end
   end

   // slave answer straight back, only inside our own cycle
   assign rsp_o = '{dat: wbs_dat_i,
                    ack: busy_q && wbs_ack_i,
                    err: busy_q && wbs_err_i};

endmodule

`default_nettype wire

/* verilog/wbh_rsp_stage.sv */
// wishbone host response stage
// picks the response of the region in flight, makes the reserved
// region error and registers ack, err and read data to the master

`timescale 1ns/100ps
`default_nettype none

module wbh_rsp_stage (
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   input  logic              req_vld_i,
   input  wbh_pkg::region_e  region_i,
   input  wbh_pkg::wb_rsp_t  local_rsp_i,
   input  wbh_pkg::wb_rsp_t  ext_rsp_i,
   output logic [31:0]       wbm_dat_o,
   output logic              wbm_ack_o,
   output logic              wbm_err_o,
   output logic              rsp_pend_o          // ack/err registered next edge
);

   wbh_pkg::region_e region_q;
   logic             rsvd_err_q;
   wbh_pkg::wb_rsp_t sel_rsp;

   // ------------------------------------------------
   // response select
   // ------------------------------------------------
   always_comb
   begin
      case (region_q)
         wbh_pkg::REGION_LOCAL: sel_rsp = local_rsp_i;
         wbh_pkg::REGION_RSVD:  sel_rsp = '{dat: 32'h0, ack: 1'b0, err: rsvd_err_q};
         default:               sel_rsp = ext_rsp_i;
      endcase
   end

   assign rsp_pend_o = sel_rsp.ack || sel_rsp.err;

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         region_q   <= wbh_pkg::REGION_EXT;
         rsvd_err_q <= 1'b0;
         wbm_ack_o  <= 1'b0;
         wbm_err_o  <= 1'b0;
         wbm_dat_o  <= 32'h0;
      end
      else
      begin
         if (req_vld_i)
            region_q <= region_i;                // held until next request
         rsvd_err_q <= req_vld_i && (region_i == wbh_pkg::REGION_RSVD);
         wbm_ack_o  <= sel_rsp.ack;
         wbm_err_o  <= sel_rsp.err;
         if (sel_rsp.ack)
            wbm_dat_o <= sel_rsp.dat;            // last data stays on the bus
      end
   end

endmodule

`default_nettype wire

/* verilog/wb_host.sv */
// wishbone host top level
// request stage, local config registers, external slave port
// and response stage on the single master clock

`timescale 1ns/100ps
`default_nettype none

module wb_host #(
   parameter logic [31:0] CLK_CTRL1_RESET = 32'h0,
   parameter logic [31:0] CLK_CTRL2_RESET = 32'h0
) (
   input  logic        wbm_clk_i,
   input  logic        wbm_rst_n,

   // master port
   input  logic        wbm_cyc_i,
   input  logic        wbm_stb_i,
   input  logic [31:0] wbm_adr_i,
   input  logic        wbm_we_i,
   input  logic [31:0] wbm_dat_i,
   input  logic [3:0]  wbm_sel_i,
   output logic [31:0] wbm_dat_o,
   output logic        wbm_ack_o,
   output logic        wbm_err_o,

   // slave port
   output logic        wbs_cyc_o,
   output logic        wbs_stb_o,
   output logic [31:0] wbs_adr_o,
   output logic        wbs_we_o,
   output logic [31:0] wbs_dat_o,
   output logic [3:0]  wbs_sel_o,
   input  logic [31:0] wbs_dat_i,
   input  logic        wbs_ack_i,
   input  logic        wbs_err_i,

   // sw resets and clock config
   output logic        wbd_int_rst_n_o,
   output logic        bist_rst_n_o,
   output logic        mac_rst_n_o,
   output logic [31:0] cfg_clk_ctrl1_o,
   output logic [31:0] cfg_clk_ctrl2_o
);

   // ------------------------------------------------
   // stage to stage wires
   // ------------------------------------------------
   logic             req_vld;
   wbh_pkg::wb_req_t req;
   wbh_pkg::region_e region;
   logic             local_sel;
   logic             ext_sel;
   wbh_pkg::wb_rsp_t local_rsp;
   wbh_pkg::wb_rsp_t ext_rsp;
   logic [15:0]      bank_sel;
   logic             rsp_ack;
   logic             rsp_pend;

   assign local_sel = req_vld && (region == wbh_pkg::REGION_LOCAL);
   assign ext_sel   = req_vld && (region == wbh_pkg::REGION_EXT);
   assign rsp_ack   = wbm_ack_o || wbm_err_o;   // response leaving

   wbh_req_stage u_req (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .wbm_cyc_i (wbm_cyc_i), .wbm_stb_i (wbm_stb_i),
      .wbm_adr_i (wbm_adr_i), .wbm_we_i  (wbm_we_i),
      .wbm_dat_i (wbm_dat_i), .wbm_sel_i (wbm_sel_i),
      .rsp_ack_i (rsp_ack),   .rsp_pend_i (rsp_pend),
      .req_vld_o (req_vld),   .req_o (req), .region_o (region)
   );

   wbh_local_regs #(
      .CLK_CTRL1_RESET (CLK_CTRL1_RESET),
      .CLK_CTRL2_RESET (CLK_CTRL2_RESET)
   ) u_regs (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .sel_i (local_sel), .req_i (req), .rsp_o (local_rsp),
      .glb_ctrl_o ({mac_rst_n_o, bist_rst_n_o, wbd_int_rst_n_o}),  // bits 2..0
      .bank_sel_o (bank_sel),
      .clk_ctrl1_o (cfg_clk_ctrl1_o), .clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

   wbh_ext_port u_ext (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .sel_i (ext_sel), .req_i (req), .bank_sel_i (bank_sel),
      .wbs_cyc_o (wbs_cyc_o), .wbs_stb_o (wbs_stb_o),
      .wbs_adr_o (wbs_adr_o), .wbs_we_o  (wbs_we_o),
      .wbs_dat_o (wbs_dat_o), .wbs_sel_o (wbs_sel_o),
      .wbs_dat_i (wbs_dat_i), .wbs_ack_i (wbs_ack_i), .wbs_err_i (wbs_err_i),
      .rsp_o (ext_rsp)
   );

   wbh_rsp_stage u_rsp (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .req_vld_i (req_vld), .region_i (region),
      .local_rsp_i (local_rsp), .ext_rsp_i (ext_rsp),
      .wbm_dat_o (wbm_dat_o), .wbm_ack_o (wbm_ack_o), .wbm_err_o (wbm_err_o),
      .rsp_pend_o (rsp_pend)
   );

endmodule

`default_nettype wire

/* tb/wb_host_assertions.sv */
// wishbone host checker bound into the top level
// shadow register model from observed writes, protocol timing
// and data checks on both the master and slave sides

`timescale 1ns/100ps
`default_nettype none

module wb_host_assertions #(
   parameter logic [31:0] CLK_CTRL1_RESET = 32'h0,
   parameter logic [31:0] CLK_CTRL2_RESET = 32'h0
) (
   input logic              wbm_clk_i,
   input logic              wbm_rst_n,
   input logic              req_vld_i,
   input wbh_pkg::wb_req_t  req_i,              // request as held by the master
   input logic [31:0]       wbm_dat_i,          // master side outputs of the DUT
   input logic              wbm_ack_i,
   input logic              wbm_err_i,
   input logic              wbs_cyc_i,
   input logic              wbs_stb_i,
   input logic [31:0]       wbs_adr_i,
   input logic              wbs_we_i,
   input logic [31:0]       wbs_dat_o_i,
   input logic [3:0]        wbs_sel_i,
   input logic [31:0]       wbs_rdat_i,         // slave read data into the DUT
   input logic              wbs_ack_i,
   input logic              wbs_err_i,
   input logic [2:0]        rst_bits_i,         // mac, bist, wbd
   input logic [31:0]       clk_ctrl1_i,
   input logic [31:0]       clk_ctrl2_i
);

   int               fail_cnt = 0;             // read by the testbench
   logic [31:0]      sh_glb;
   logic [15:0]      sh_bank;
   logic [31:0]      sh_clk1;
   logic [31:0]      sh_clk2;
   logic [31:0]      exp_rd_q;
   logic             lcl_rd_q;
   wbh_pkg::wb_req_t ext_q;                    // last external request
   logic             is_local;
   logic             is_rsvd;
   logic [31:0]      sh_rd;

   assign is_local = req_i.adr[19:18] == 2'b10;
   assign is_rsvd  = req_i.adr[19:18] == 2'b11;

   always_comb
   begin
      case (req_i.adr[3:2])
         2'd0:    sh_rd = sh_glb;
         2'd1:    sh_rd = {16'h0, sh_bank};
         2'd2:    sh_rd = sh_clk1;
         default: sh_rd = sh_clk2;
      endcase
   end

   // ------------------------------------------------
   // shadow model
   // ------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         sh_glb   <= 32'h0;
         sh_bank  <= 16'h1000;
         sh_clk1  <= CLK_CTRL1_RESET;
         sh_clk2  <= CLK_CTRL2_RESET;
         lcl_rd_q <= 1'b0;
         exp_rd_q <= 32'h0;
      end
      else if (req_vld_i)
      begin
         lcl_rd_q <= is_local && !req_i.we;
         exp_rd_q <= sh_rd;
         if (!is_local && !is_rsvd)
            ext_q <= req_i;
         if (is_local && req_i.we)
         begin
            case (req_i.adr[3:2])
               2'd0:
               begin
                  for (int b = 0; b < 4; b++)
                  begin
                     if (req_i.sel[b])
                        sh_glb[8*b +: 8] <= req_i.dat[8*b +: 8];
                  end
               end
               2'd1:    sh_bank <= req_i.dat[15:0];
               2'd2:    sh_clk1 <= req_i.dat;
               default: sh_clk2 <= req_i.dat;
            endcase
         end
      end
   end

   // ------------------------------------------------
   // checks
   // ------------------------------------------------
   a_cfg_out: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      rst_bits_i == sh_glb[2:0] && clk_ctrl1_i == sh_clk1 && clk_ctrl2_i == sh_clk2)
      else begin $error("config outputs differ from shadow"); fail_cnt++; end

   a_local_ack: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      req_vld_i && is_local |-> !wbm_ack_i ##1 !wbm_ack_i ##1 wbm_ack_i ##1 !wbm_ack_i)
      else begin $error("local ack timing"); fail_cnt++; end

   a_local_rd: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbm_ack_i && lcl_rd_q |-> wbm_dat_i == exp_rd_q)
      else begin $error("local read data"); fail_cnt++; end

   a_rsvd_err: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      req_vld_i && is_rsvd |-> !wbs_cyc_i ##1 !wbs_cyc_i ##1 (wbm_err_i && !wbs_cyc_i)
      ##1 !wbm_err_i)
      else begin $error("reserved region error timing"); fail_cnt++; end

   a_ext_fields: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_cyc_i |-> wbs_adr_i == {sh_bank[15:2], ext_q.adr[17:0]} && wbs_we_i == ext_q.we
      && wbs_dat_o_i == ext_q.dat && wbs_sel_i == ext_q.sel)
      else begin $error("slave request fields"); fail_cnt++; end

   a_ext_hold: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_cyc_i && !wbs_ack_i && !wbs_err_i |=> wbs_cyc_i && wbs_stb_i)
      else begin $error("slave cycle dropped early"); fail_cnt++; end

   a_ext_ack: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_cyc_i && wbs_ack_i |=> wbm_ack_i && wbm_dat_i == $past(wbs_rdat_i))
      else begin $error("slave ack not passed back"); fail_cnt++; end

   a_ext_err: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_cyc_i && wbs_err_i |=> wbm_err_i)
      else begin $error("slave err not passed back"); fail_cnt++; end

   a_dat_hold: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      $changed(wbm_dat_i) |-> wbm_ack_i)
      else begin $error("read data moved without ack"); fail_cnt++; end

endmodule

bind wb_host wb_host_assertions #(
   .CLK_CTRL1_RESET (CLK_CTRL1_RESET),
   .CLK_CTRL2_RESET (CLK_CTRL2_RESET)
) u_chk (
   .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
   .req_vld_i (req_vld),
   .req_i ({wbm_adr_i, wbm_we_i, wbm_dat_i, wbm_sel_i}),
   .wbm_dat_i (wbm_dat_o), .wbm_ack_i (wbm_ack_o), .wbm_err_i (wbm_err_o),
   .wbs_cyc_i (wbs_cyc_o), .wbs_stb_i (wbs_stb_o), .wbs_adr_i (wbs_adr_o),
   .wbs_we_i (wbs_we_o), .wbs_dat_o_i (wbs_dat_o), .wbs_sel_i (wbs_sel_o),
   .wbs_rdat_i (wbs_dat_i), .wbs_ack_i (wbs_ack_i), .wbs_err_i (wbs_err_i),
   .rst_bits_i ({mac_rst_n_o, bist_rst_n_o, wbd_int_rst_n_o}),
   .clk_ctrl1_i (cfg_clk_ctrl1_o), .clk_ctrl2_i (cfg_clk_ctrl2_o)
);

`default_nettype wire

/* tb/tb_wb_host.sv */
// wishbone host testbench
// master access sequence over local, external and reserved regions
// and a slave model with lfsr drawn response delays

`timescale 1ns/100ps
`default_nettype none

module tb_wb_host;

   localparam int N_ACC     = 16;             // accesses in the list below
   localparam int ACC_WORST = 10;             // worst cycles per access at slave delay 3
   localparam int CYC_LIMIT = 2 * N_ACC * ACC_WORST + 20;

   logic        wbm_clk_i = 1'b0;
   logic        wbm_rst_n = 1'b0;
   logic        wbm_cyc_i = 1'b0;
   logic        wbm_stb_i = 1'b0;
   logic [31:0] wbm_adr_i = 32'h0;
   logic        wbm_we_i  = 1'b0;
   logic [31:0] wbm_dat_i = 32'h0;
   logic [3:0]  wbm_sel_i = 4'h0;
   logic [31:0] wbs_dat_i = 32'h0;
   logic        wbs_ack_i = 1'b0;
   logic        wbs_err_i = 1'b0;
   logic [31:0] wbm_dat_o;
   logic        wbm_ack_o, wbm_err_o;
   logic        wbs_cyc_o, wbs_stb_o, wbs_we_o;
   logic [31:0] wbs_adr_o, wbs_dat_o;
   logic [3:0]  wbs_sel_o;
   logic        wbd_int_rst_n_o, bist_rst_n_o, mac_rst_n_o;
   logic [31:0] cfg_clk_ctrl1_o, cfg_clk_ctrl2_o;

   int          tb_errs = 0;
   int          cyc_cnt = 0;
   int          slv_wait = -1;                // -1 means no delay drawn yet
   logic [15:0] lfsr_q = 16'd16354;
   logic [31:0] slv_cnt = 32'h5a00_0000;     // read data counter

   wb_host #(
      .CLK_CTRL1_RESET (32'h1234_5678),
      .CLK_CTRL2_RESET (32'h0bad_f00d)
   ) uut (.*);

   always #2 wbm_clk_i = ~wbm_clk_i;         // 4 ns period

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // ------------------------------------------------
   // slave model
   // ------------------------------------------------
   always @(posedge wbm_clk_i)
   begin
      wbs_ack_i <= 1'b0;
      wbs_err_i <= 1'b0;
      if (wbs_cyc_o && !wbs_ack_i && !wbs_err_i)
      begin
         if (slv_wait < 0)
         begin
            slv_wait = {31'd0, lfsr_q[0]};   // delay 0..3 from two lfsr bits
            lfsr_q   = lfsr_step(lfsr_q);
            slv_wait = slv_wait * 2 + {31'd0, lfsr_q[0]};
            lfsr_q   = lfsr_step(lfsr_q);
         end
         if (slv_wait == 0)
         begin
            if (wbs_adr_o[17:0] == 18'h3_fff0)
               wbs_err_i <= 1'b1;            // the one failing address
            else
               wbs_ack_i <= 1'b1;
            wbs_dat_i <= slv_cnt;
            slv_cnt   <= slv_cnt + 32'd1;
            slv_wait = -1;
         end
         else
            slv_wait = slv_wait - 1;
      end
   end

   // run limit
   always @(posedge wbm_clk_i)
   begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt > CYC_LIMIT)
      begin
         $display("timeout: run exceeded %0d cycles", CYC_LIMIT);
         $display("Result: FAILED");
         $finish;
      end
   end

   // one classic access held until ack or err
   task automatic wb_access(input logic [31:0] adr, input logic we,
                            input logic [31:0] dat, input logic [3:0] sel);
      int n;
      n = 0;
      @(posedge wbm_clk_i);
      wbm_cyc_i <= 1'b1;
      wbm_stb_i <= 1'b1;
      wbm_adr_i <= adr;
      wbm_we_i  <= we;
      wbm_dat_i <= dat;
      wbm_sel_i <= sel;
      do
      begin
         @(posedge wbm_clk_i);
         n++;
      end
      while (!wbm_ack_o && !wbm_err_o && n < 20);
      if (!wbm_ack_o && !wbm_err_o)
      begin
         $display("ERROR @%0t: no response for address %h", $time, adr);
         tb_errs++;
      end
      wbm_cyc_i <= 1'b0;                     // drop in the cycle after response
      wbm_stb_i <= 1'b0;
   endtask

   // ------------------------------------------------
   // access list
   // ------------------------------------------------
   initial
   begin
      repeat (5) @(posedge wbm_clk_i);
      wbm_rst_n <= 1'b1;
      // reset values
      wb_access(32'h0008_0000, 1'b0, 32'h0, 4'hf);
      wb_access(32'h0008_0004, 1'b0, 32'h0, 4'hf);
      wb_access(32'h0008_0008, 1'b0, 32'h0, 4'hf);
      wb_access(32'h0008_000c, 1'b0, 32'h0, 4'hf);
      // byte enables and config outputs
      wb_access(32'h0008_0000, 1'b1, 32'ha5a5_a5a2, 4'b0101);
      wb_access(32'h0008_0000, 1'b0, 32'h0, 4'hf);
      wb_access(32'h0008_0000, 1'b1, 32'h0000_0005, 4'b0001);
      wb_access(32'h0008_0008, 1'b1, 32'hcafe_0001, 4'hf);
      wb_access(32'h0008_000c, 1'b1, 32'hcafe_0002, 4'hf);
      // bank select then external traffic
      wb_access(32'h0008_0004, 1'b1, 32'h1234_beef, 4'hf);
      wb_access(32'h0008_0004, 1'b0, 32'h0, 4'hf);
      wb_access(32'h0001_2344, 1'b1, 32'hdead_0042, 4'b1100);
      wb_access(32'h0002_0010, 1'b0, 32'h0, 4'hf);
      wb_access(32'h0007_fff0, 1'b0, 32'h0, 4'hf);   // slave errs here
      // reserved region followed by a local read
      wb_access(32'h000c_0010, 1'b0, 32'h0, 4'hf);
      wb_access(32'h0008_0008, 1'b0, 32'h0, 4'hf);
      repeat (4) @(posedge wbm_clk_i);
      $display("errors: testbench %0d, assertions %0d", tb_errs, uut.u_chk.fail_cnt);
      if (tb_errs == 0 && uut.u_chk.fail_cnt == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
verilog/wbh_pkg.sv
verilog/wbh_req_stage.sv
verilog/wbh_local_regs.sv
verilog/wbh_ext_port.sv
verilog/wbh_rsp_stage.sv
verilog/wb_host.sv
tb/wb_host_assertions.sv
tb/tb_wb_host.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the wishbone host testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_wb_host -f verilog.f -o sim_wb_host

out=$(./obj_dir/sim_wb_host)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -q "^Result: PASSED$"
